/* compile.f */
+incdir+hw
hw/aes_pkg.sv
hw/aes_ctrl.sv
hw/aes_key_expand.sv
hw/aes_key_ram.sv
hw/aes_enc_round.sv
hw/aes_dec_round.sv
hw/aes_top.sv
tb/tb_clk_gen.sv
tb/aes_asserts.sv
tb/aes_tb.sv

/* hw/aes_cfg.svh */
`ifndef AES_CFG_SVH
`define AES_CFG_SVH

// block and key width in bits.
`define AES_BLK_W 128

`define AES_NR    10
`define AES_NKEYS 11

// command word, code 0 is a no-op.
`define AES_CMD_W       2
`define AES_CMD_SET_KEY 2'd1
`define AES_CMD_ENCRYPT 2'd2
`define AES_CMD_DECRYPT 2'd3

`endif

/* hw/aes_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aes_cfg.svh"

module aes_ctrl import aes_pkg::*; (
        input  wire                  clk,
        input  wire                  rst_n,
        input  wire                  en,
        input  wire [`AES_CMD_W-1:0] cmd,
        input  wire aes_blk_t        enc_state,
        input  wire aes_blk_t        dec_state,
        output logic                 kx_load,
        output logic                 kx_step,
        output logic                 ram_we,
        output rk_addr_t             ram_addr,
        output logic                 enc_load,
        output logic                 enc_step,
        output logic                 enc_last,
        output logic                 dec_load,
        output logic                 dec_step,
        output logic                 dec_last,
        output aes_blk_t             out_blk,
        output logic                 busy,
        output logic                 en_o
);

        typedef enum logic [1:0] {ST_IDLE, ST_KEY, ST_ENC, ST_DEC} state_t;

        localparam rk_addr_t LAST_RK   = rk_addr_t'(`AES_NR);
        localparam rk_addr_t KEY_END   = rk_addr_t'(`AES_NKEYS);
        localparam rk_addr_t FINAL_RND = rk_addr_t'(`AES_NR + 1);
        localparam rk_addr_t BLK_END   = rk_addr_t'(`AES_NR + 2);

        state_t   st;
        rk_addr_t cnt;
        logic     start;
        logic     blk_step;
        logic     blk_last;

        assign busy  = (st != ST_IDLE);
        assign start = en && !busy;

        assign kx_load  = start && (cmd == `AES_CMD_SET_KEY);
        assign enc_load = start && (cmd == `AES_CMD_ENCRYPT); // input captured at edge 0.
        assign dec_load = start && (cmd == `AES_CMD_DECRYPT);

        // round keys 0..10 written on the cycles after the load.
        assign ram_we  = (st == ST_KEY) && (cnt < KEY_END);
        assign kx_step = ram_we && (cnt != LAST_RK);

        assign ram_addr = (st == ST_DEC) ? LAST_RK - cnt : cnt;

        // cnt 1 adds key 0, then ten rounds. key for each is read one cycle ahead.
        assign blk_step = (cnt != '0) && (cnt != BLK_END);
        assign blk_last = (cnt == FINAL_RND);

        assign enc_step = (st == ST_ENC) && blk_step;
        assign enc_last = (st == ST_ENC) && blk_last;
        assign dec_step = (st == ST_DEC) && blk_step;
        assign dec_last = (st == ST_DEC) && blk_last;

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        st      <= ST_IDLE;
                        cnt     <= '0;
                        en_o    <= 1'b0;
                        out_blk <= '0;
                end else begin
                        en_o <= 1'b0;
                        case (st)
                        ST_IDLE: begin
                                cnt <= '0;
                                if (en) begin
                                        case (cmd)
                                        `AES_CMD_SET_KEY: st <= ST_KEY;
                                        `AES_CMD_ENCRYPT: st <= ST_ENC;
                                        `AES_CMD_DECRYPT: st <= ST_DEC;
                                        default:          st <= ST_IDLE; // no-op.
                                        endcase
                                end
                        end
                        ST_KEY: begin
                                if (cnt == KEY_END) begin
                                        st   <= ST_IDLE;
                                        en_o <= 1'b1;
                                end else begin
                                        cnt <= cnt + 4'd1;
                                end
                        end
                        default: begin
                                if (cnt == BLK_END) begin
                                        st      <= ST_IDLE;
                                        en_o    <= 1'b1;
                                        out_blk <= (st == ST_ENC) ? enc_state : dec_state;
                                end else begin
                                        cnt <= cnt + 4'd1;
                                end
                        end
                        endcase
                end
        end

endmodule

`default_nettype wire

/* hw/aes_dec_round.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_dec_round import aes_pkg::*; (
        input  wire           clk,
        input  wire           rst_n,
        input  wire           dec_load,
        input  wire           dec_step,
        input  wire           dec_last,
        input  wire aes_blk_t in_blk,
        input  wire aes_blk_t rk_rd,
        output aes_blk_t      dec_state
);

        aes_blk_t isr_isb;
        aes_blk_t ark;
        aes_blk_t imixed;
        logic     ark_pend;

        function automatic aes_word_t inv_mix_col(input aes_word_t w);
                logic [7:0] a0, a1, a2, a3;
                a0 = w[31:24];
                a1 = w[23:16];
                a2 = w[15:8];
                a3 = w[7:0];
                return {gmul(8'h0e, a0) ^ gmul(8'h0b, a1) ^ gmul(8'h0d, a2) ^ gmul(8'h09, a3),
                        gmul(8'h09, a0) ^ gmul(8'h0e, a1) ^ gmul(8'h0b, a2) ^ gmul(8'h0d, a3),
                        gmul(8'h0d, a0) ^ gmul(8'h09, a1) ^ gmul(8'h0e, a2) ^ gmul(8'h0b, a3),
                        gmul(8'h0b, a0) ^ gmul(8'h0d, a1) ^ gmul(8'h09, a2) ^ gmul(8'h0e, a3)};
        endfunction

        // invshiftrows moves row r of column c to column c + r.
        always_comb begin
                for (int c = 0; c < 4; c++) begin
                        for (int r = 0; r < 4; r++) begin
                                isr_isb[127 - 8 * (r + 4 * ((c + r) % 4)) -: 8] =
                                        inv_sbox(dec_state[127 - 8 * (r + 4 * c) -: 8]);
                        end
                end
        end

        assign ark = isr_isb ^ rk_rd;

        always_comb begin
                for (int c = 0; c < 4; c++)
                        imixed[127 - 32 * c -: 32] = inv_mix_col(ark[127 - 32 * c -: 32]);
        end

        always_ff @(posedge clk) begin
                if (!rst_n)
                        ark_pend <= 1'b0;
                else if (dec_load)
                        ark_pend <= 1'b1;
                else if (dec_step)
                        ark_pend <= 1'b0;
        end

        // keys arrive from index 10 down to 0.
        always_ff @(posedge clk) begin
                if (dec_load) begin
                        dec_state <= in_blk;
                end else if (dec_step) begin
                        if (ark_pend)
                                dec_state <= dec_state ^ rk_rd;
                        else if (dec_last)
                                dec_state <= ark;
                        else
                                dec_state <= imixed;
                end
        end

endmodule

`default_nettype wire

/* hw/aes_enc_round.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_enc_round import aes_pkg::*; (
        input  wire           clk,
        input  wire           rst_n,
        input  wire           enc_load,
        input  wire           enc_step,
        input  wire           enc_last,
        input  wire aes_blk_t in_blk,
        input  wire aes_blk_t rk_rd,
        output aes_blk_t      enc_state
);

        aes_blk_t sb_sr;
        aes_blk_t mixed;
        logic     ark_pend;

        function automatic aes_word_t mix_col(input aes_word_t w);
                logic [7:0] a0, a1, a2, a3;
                a0 = w[31:24];
                a1 = w[23:16];
                a2 = w[15:8];
                a3 = w[7:0];
                return {gmul(8'h02, a0) ^ gmul(8'h03, a1) ^ a2 ^ a3,
                        a0 ^ gmul(8'h02, a1) ^ gmul(8'h03, a2) ^ a3,
                        a0 ^ a1 ^ gmul(8'h02, a2) ^ gmul(8'h03, a3),
                        gmul(8'h03, a0) ^ a1 ^ a2 ^ gmul(8'h02, a3)};
        endfunction

        // subbytes and shiftrows, row r of column c comes from column c + r.
        always_comb begin
                for (int c = 0; c < 4; c++) begin
                        for (int r = 0; r < 4; r++) begin
                                sb_sr[127 - 8 * (r + 4 * c) -: 8] =
                                        sbox(enc_state[127 - 8 * (r + 4 * ((c + r) % 4)) -: 8]);
                        end
                end
        end

        always_comb begin
                for (int c = 0; c < 4; c++)
                        mixed[127 - 32 * c -: 32] = mix_col(sb_sr[127 - 32 * c -: 32]);
        end

        // first step after a load is the plain addroundkey with key 0.
        always_ff @(posedge clk) begin
                if (!rst_n)
                        ark_pend <= 1'b0;
                else if (enc_load)
                        ark_pend <= 1'b1;
                else if (enc_step)
                        ark_pend <= 1'b0;
        end

        always_ff @(posedge clk) begin
                if (enc_load) begin
                        enc_state <= in_blk;
                end else if (enc_step) begin
                        if (ark_pend)
                                enc_state <= enc_state ^ rk_rd;
                        else if (enc_last)
                                enc_state <= sb_sr ^ rk_rd; // no mixcolumns in round 10.
                        else
                                enc_state <= mixed ^ rk_rd;
                end
        end

endmodule

`default_nettype wire

/* hw/aes_key_expand.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_key_expand import aes_pkg::*; (
        input  wire           clk,
        input  wire           rst_n,
        input  wire           kx_load,
        input  wire           kx_step,
        input  wire rk_addr_t ram_addr,
        input  wire aes_blk_t key,
        output aes_blk_t      rk_next
);

        aes_word_t  w0, w1, w2, w3;
        aes_word_t  tmp;
        aes_word_t  n0, n1, n2, n3;
        logic [7:0] rcon;

        assign w0 = rk_next[127:96];
        assign w1 = rk_next[95:64];
        assign w2 = rk_next[63:32];
        assign w3 = rk_next[31:0];

        // ram_addr is the key being written, so the next one needs rcon[ram_addr + 1].
        always_comb begin
                case (ram_addr)
                4'd0:    rcon = 8'h01;
                4'd1:    rcon = 8'h02;
                4'd2:    rcon = 8'h04;
                4'd3:    rcon = 8'h08;
                4'd4:    rcon = 8'h10;
                4'd5:    rcon = 8'h20;
                4'd6:    rcon = 8'h40;
                4'd7:    rcon = 8'h80;
                4'd8:    rcon = 8'h1b;
                4'd9:    rcon = 8'h36;
                default: rcon = 8'h00;
                endcase
        end

        // subword of rotword, then the round constant on the top byte.
        assign tmp = {sbox(w3[23:16]), sbox(w3[15:8]), sbox(w3[7:0]), sbox(w3[31:24])}
                     ^ {rcon, 24'h000000};

        assign n0 = w0 ^ tmp;
        assign n1 = w1 ^ n0;
        assign n2 = w2 ^ n1;
        assign n3 = w3 ^ n2;

        always_ff @(posedge clk) begin
                if (!rst_n)
                        rk_next <= '0;
                else if (kx_load)
                        rk_next <= key;
                else if (kx_step)
                        rk_next <= {n0, n1, n2, n3};
        end

endmodule

`default_nettype wire

/* hw/aes_key_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aes_cfg.svh"

module aes_key_ram import aes_pkg::*; (
        input  wire           clk,
        input  wire           ram_we,
        input  wire rk_addr_t ram_addr,
        input  wire aes_blk_t rk_next,
        output aes_blk_t      rk_rd
);

        aes_blk_t mem [`AES_NKEYS];

        always_ff @(posedge clk) begin
                if (ram_we)
                        mem[ram_addr] <= rk_next;
                // the controller runs past key 10 at the end of a block.
                if (ram_addr < rk_addr_t'(`AES_NKEYS))
                        rk_rd <= mem[ram_addr];
        end

endmodule

`default_nettype wire

/* hw/aes_pkg.sv */
`default_nettype none

`include "aes_cfg.svh"

package aes_pkg;

        // byte 0 is the msb, state bytes stored column-major.
        typedef logic [`AES_BLK_W-1:0] aes_blk_t;
        typedef logic [31:0]           aes_word_t;
        typedef logic [3:0]            rk_addr_t;

        localparam logic [0:255][7:0] SBOX_T = {
                128'h637c777bf26b6fc53001672bfed7ab76,
                128'hca82c97dfa5947f0add4a2af9ca472c0,
                128'hb7fd9326363ff7cc34a5e5f171d83115,
                128'h04c723c31896059a071280e2eb27b275,
                128'h09832c1a1b6e5aa0523bd6b329e32f84,
                128'h53d100ed20fcb15b6acbbe394a4c58cf,
                128'hd0efaafb434d338545f9027f503c9fa8,
                128'h51a3408f929d38f5bcb6da2110fff3d2,
                128'hcd0c13ec5f974417c4a77e3d645d1973,
                128'h60814fdc222a908846eeb814de5e0bdb,
                128'he0323a0a4906245cc2d3ac629195e479,
                128'he7c8376d8dd54ea96c56f4ea657aae08,
                128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
                128'h703eb5664803f60e613557b986c11d9e,
                128'he1f8981169d98e949b1e87e9ce5528df,
                128'h8ca1890dbfe6426841992d0fb054bb16
        };

        localparam logic [0:255][7:0] INV_SBOX_T = {
                128'h52096ad53036a538bf40a39e81f3d7fb,
                128'h7ce339829b2fff87348e4344c4dee9cb,
                128'h547b9432a6c2233dee4c950b42fac34e,
                128'h082ea16628d924b2765ba2496d8bd125,
                128'h72f8f66486689816d4a45ccc5d65b692,
                128'h6c704850fdedb9da5e154657a78d9d84,
                128'h90d8ab008cbcd30af7e45805b8b34506,
                128'hd02c1e8fca3f0f02c1afbd0301138a6b,
                128'h3a9111414f67dcea97f2cfcef0b4e673,
                128'h96ac7422e7ad3585e2f937e81c75df6e,
                128'h47f11a711d29c5896fb7620eaa18be1b,
                128'hfc563e4bc6d279209adbc0fe78cd5af4,
                128'h1fdda8338807c731b11210592780ec5f,
                128'h60517fa919b54a0d2de57a9f93c99cef,
                128'ha0e03b4dae2af5b0c8ebbb3c83539961,
                128'h172b047eba77d626e169146355210c7d
        };

        function automatic logic [7:0] sbox(input logic [7:0] b);
                return SBOX_T[b];
        endfunction

        function automatic logic [7:0] inv_sbox(input logic [7:0] b);
                return INV_SBOX_T[b];
        endfunction

        // shift-and-add product, reduced by x^8 + x^4 + x^3 + x + 1.
        function automatic logic [7:0] gmul(input logic [7:0] a, input logic [7:0] b);
                logic [7:0] p;
                logic [7:0] x;
                p = 8'h00;
                x = a;
                for (int i = 0; i < 8; i++) begin
                        if (b[i])
                                p = p ^ x;
                        x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00); // xtime.
                end
                return p;
        endfunction

endpackage

`default_nettype wire

/* hw/aes_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aes_cfg.svh"

module aes_top import aes_pkg::*; (
        input  wire                  clk,
        input  wire                  rst_n,
        input  wire                  en,
        input  wire [`AES_CMD_W-1:0] cmd,
        input  wire aes_blk_t        key,
        input  wire aes_blk_t        in_blk,
        output aes_blk_t             out_blk,
        output logic                 busy,
        output logic                 en_o
);

        logic     kx_load;
        logic     kx_step;
        logic     ram_we;
        rk_addr_t ram_addr;
        aes_blk_t rk_next;
        aes_blk_t rk_rd;
        logic     enc_load, enc_step, enc_last;
        logic     dec_load, dec_step, dec_last;
        aes_blk_t enc_state;
        aes_blk_t dec_state;

        aes_ctrl u_ctrl (
                .clk       (clk),
                .rst_n     (rst_n),
                .en        (en),
                .cmd       (cmd),
                .enc_state (enc_state),
                .dec_state (dec_state),
                .kx_load   (kx_load),
                .kx_step   (kx_step),
                .ram_we    (ram_we),
                .ram_addr  (ram_addr),
                .enc_load  (enc_load),
                .enc_step  (enc_step),
                .enc_last  (enc_last),
                .dec_load  (dec_load),
                .dec_step  (dec_step),
                .dec_last  (dec_last),
                .out_blk   (out_blk),
                .busy      (busy),
                .en_o      (en_o)
        );

        aes_key_expand u_key_expand (
                .clk      (clk),
                .rst_n    (rst_n),
                .kx_load  (kx_load),
                .kx_step  (kx_step),
                .ram_addr (ram_addr),
                .key      (key),
                .rk_next  (rk_next)
        );

        aes_key_ram u_key_ram (
                .clk      (clk),
                .ram_we   (ram_we),
                .ram_addr (ram_addr),
                .rk_next  (rk_next),
                .rk_rd    (rk_rd)
        );

        aes_enc_round u_enc_round (
                .clk       (clk),
                .rst_n     (rst_n),
                .enc_load  (enc_load),
                .enc_step  (enc_step),
                .enc_last  (enc_last),
                .in_blk    (in_blk),
                .rk_rd     (rk_rd),
                .enc_state (enc_state)
        );

        aes_dec_round u_dec_round (
                .clk       (clk),
                .rst_n     (rst_n),
                .dec_load  (dec_load),
                .dec_step  (dec_step),
                .dec_last  (dec_last),
                .in_blk    (in_blk),
                .rk_rd     (rk_rd),
                .dec_state (dec_state)
        );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the AES testbench with Verilator and run it from the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/aes_sim

verilator --binary --timing --assert -f compile.f --top-module aes_tb \
        -Mdir obj_dir -o aes_sim
if [ $? -ne 0 ]; then
        echo "verilator build failed"
        exit 1
fi

"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
        echo "simulation FAILED"
        exit 1
fi
if [ $run_status -ne 0 ]; then
        echo "simulation exited with status $run_status"
        exit 1
fi

echo "simulation PASSED"
exit 0

/* tb/aes_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_asserts (
        input wire clk,
        input wire rst_n,
        input wire busy,
        input wire en_o,
        input wire ram_we
);

        // done is a single-cycle pulse.
        en_o_single: assert property (@(posedge clk) disable iff (!rst_n) en_o |=> !en_o)
                else $error("en_o stayed high for two cycles");

        en_o_after_busy: assert property (@(posedge clk) disable iff (!rst_n)
                en_o |-> $past(busy))
                else $error("en_o pulsed without busy in the previous cycle");

        we_while_busy: assert property (@(posedge clk) disable iff (!rst_n) ram_we |-> busy)
                else $error("key RAM written while idle");

        // any reset cycle leaves the core idle.
        idle_after_reset: assert property (@(posedge clk) !rst_n |=> !busy)
                else $error("busy high in the first cycle after reset");

endmodule

`default_nettype wire

/* tb/aes_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aes_cfg.svh"

module aes_tb;

        localparam int TIMEOUT_CYCLES = 100;
        localparam int SEED           = 12930;
        localparam int KEY_LAT        = 12;
        localparam int BLK_LAT        = 13;
        localparam int N_RANDOM       = 20;

        // FIPS-197 appendix C.1 and appendix B vectors.
        localparam logic [127:0] KEY_C1 = 128'h000102030405060708090a0b0c0d0e0f;
        localparam logic [127:0] PT_C1  = 128'h00112233445566778899aabbccddeeff;
        localparam logic [127:0] CT_C1  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
        localparam logic [127:0] KEY_B  = 128'h2b7e151628aed2a6abf7158809cf4f3c;
        localparam logic [127:0] PT_B   = 128'h3243f6a8885a308d313198a2e0370734;
        localparam logic [127:0] CT_B   = 128'h3925841d02dc09fbdc118597196a0b32;

        logic                  clk;
        logic                  rst_n;
        logic                  en;
        logic [`AES_CMD_W-1:0] cmd;
        logic [127:0]          key;
        logic [127:0]          in_blk;
        logic [127:0]          out_blk;
        logic                  busy;
        logic                  en_o;

        tb_clk_gen u_clk_gen (
                .clk   (clk),
                .rst_n (rst_n)
        );

        aes_top DUT (
                .clk     (clk),
                .rst_n   (rst_n),
                .en      (en),
                .cmd     (cmd),
                .key     (key),
                .in_blk  (in_blk),
                .out_blk (out_blk),
                .busy    (busy),
                .en_o    (en_o)
        );

        bind aes_top aes_asserts u_asserts (
                .clk    (clk),
                .rst_n  (rst_n),
                .busy   (busy),
                .en_o   (en_o),
                .ram_we (ram_we)
        );

        task automatic check(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
                if (actual !== expected) begin
                        $display("MISMATCH %s expected %h actual %h", name, expected, actual);
                        $display("Test failures found");
                        $fatal(1, "stopped at the first mismatch");
                end
        endtask

        task automatic report_timeout(input string name);
                $display("%s: no en_o from the core within %0d cycles", name, TIMEOUT_CYCLES);
                $display("Test failures found");
                $fatal(1, "stopped on a timeout");
        endtask

        function automatic logic [127:0] rand_blk();
                return {$urandom(), $urandom(), $urandom(), $urandom()};
        endfunction

        // drives one command on a falling edge, sampled at the next rising edge.
        task automatic issue(input logic [`AES_CMD_W-1:0] c, input logic [127:0] k,
                             input logic [127:0] b);
                @(negedge clk);
                en     = 1'b1;
                cmd    = c;
                key    = k;
                in_blk = b;
        endtask

        // counts rising edges from the one that took en until en_o is seen.
        task automatic wait_done(input string name, output int cycles);
                int  n;
                bit  seen;
                n    = 0;
                seen = 1'b0;
                while (!seen && n < TIMEOUT_CYCLES) begin
                        @(negedge clk);
                        en  = 1'b0;
                        cmd = '0;
                        if (en_o)
                                seen = 1'b1;
                        else
                                n++;
                end
                if (!seen)
                        report_timeout(name);
                cycles = n;
        endtask

        task automatic run_cmd(input string name, input logic [`AES_CMD_W-1:0] c,
                               input logic [127:0] k, input logic [127:0] b,
                               input int exp_lat);
                int lat;
                issue(c, k, b);
                wait_done(name, lat);
                check({name, " latency"}, 128'(exp_lat), 128'(lat));
                check({name, " busy at done"}, 0, 128'(busy));
                @(negedge clk);
                check({name, " en_o width"}, 0, 128'(en_o));
        endtask

        task automatic set_key(input string name, input logic [127:0] k);
                run_cmd(name, `AES_CMD_SET_KEY, k, '0, KEY_LAT);
        endtask

        task automatic encrypt(input string name, input logic [127:0] b,
                               output logic [127:0] res);
                run_cmd(name, `AES_CMD_ENCRYPT, '0, b, BLK_LAT);
                res = out_blk;
        endtask

        task automatic decrypt(input string name, input logic [127:0] b,
                               output logic [127:0] res);
                run_cmd(name, `AES_CMD_DECRYPT, '0, b, BLK_LAT);
                res = out_blk;
        endtask

        task automatic test_reset();
                int n;
                n = 0;
                while (!rst_n && n < TIMEOUT_CYCLES) begin
                        @(posedge clk);
                        n++;
                end
                if (!rst_n) begin
                        $display("reset was never released");
                        $display("Test failures found");
                        $fatal(1, "stopped on a timeout");
                end
                @(negedge clk);
                check("reset busy", 0, 128'(busy));
                check("reset en_o", 0, 128'(en_o));
                check("reset out_blk", 0, out_blk);
        endtask

        task automatic test_fips_encrypt();
                logic [127:0] res;
                set_key("fips_c1 set_key", KEY_C1);
                encrypt("fips_c1 encrypt", PT_C1, res);
                check("fips_c1 encrypt", CT_C1, res);
        endtask

        task automatic test_fips_decrypt();
                logic [127:0] res;
                decrypt("fips_c1 decrypt", CT_C1, res);
                check("fips_c1 decrypt", PT_C1, res);
                set_key("fips_b set_key", KEY_B); // re-key with the appendix B key.
                encrypt("fips_b encrypt", PT_B, res);
                check("fips_b encrypt", CT_B, res);
                decrypt("fips_b decrypt", CT_B, res);
                check("fips_b decrypt", PT_B, res);
        endtask

        task automatic test_round_trip();
                logic [127:0] blk;
                logic [127:0] ct;
                logic [127:0] pt;
                string        name;
                set_key("round_trip set_key", rand_blk());
                for (int i = 0; i < N_RANDOM; i++) begin
                        name = $sformatf("round_trip[%0d]", i);
                        blk  = rand_blk();
                        encrypt(name, blk, ct);
                        decrypt(name, ct, pt);
                        check(name, blk, pt);
                end
        endtask

        task automatic test_busy_ignored();
                int n;
                int pulses;
                set_key("busy set_key", KEY_C1);
                issue(`AES_CMD_ENCRYPT, '0, PT_C1);
                @(negedge clk);
                en = 1'b0;
                @(negedge clk);
                en     = 1'b1; // taken two edges after the encrypt.
                cmd    = `AES_CMD_DECRYPT;
                in_blk = CT_B;
                n      = 0;
                pulses = 0;
                while (n < 2 * BLK_LAT + 4) begin
                        @(negedge clk);
                        en  = 1'b0;
                        cmd = '0;
                        if (en_o)
                                pulses++;
                        n++;
                end
                check("busy ignored en_o count", 1, 128'(pulses));
                check("busy ignored out_blk", CT_C1, out_blk);
                set_key("busy set_key after", KEY_B);
                check("busy out_blk kept", CT_C1, out_blk);
        endtask

        initial begin
                en     = 1'b0;
                cmd    = '0;
                key    = '0;
                in_blk = '0;
                void'($urandom(SEED));

                test_reset();
                test_fips_encrypt();
                test_fips_decrypt();
                test_round_trip();
                test_busy_ignored();

                $display("All tests passed!");
                $finish;
        end

endmodule

`default_nettype wire

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
        parameter int HALF_PERIOD_NS = 4,
        parameter int RST_CYCLES     = 16
) (
        output logic clk,
        output logic rst_n
);

        initial begin
                clk = 1'b0;
                forever #HALF_PERIOD_NS clk = ~clk;
        end

        // release on a falling edge, away from the sampling edge.
        initial begin
                rst_n = 1'b0;
                repeat (RST_CYCLES) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1;
        end

endmodule

`default_nettype wire
